// File: cache_ctrl.sv
// data cache controller FSM
`timescale 1ns/10ps
`default_nettype none

`include "dcache_macros.svh"

module cache_ctrl (
	input  wire                    clk,
	input  wire                    proc_reset,
	input  wire                    proc_read,
	input  wire                    proc_write,
	input  wire                    hit,
	input  wire                    victim_dirty,
	input  wire  [`DC_TAG_W-1:0]   victim_tag,
	input  wire  [`DC_INDEX_W-1:0] index,
	input  wire  [`DC_BLOCK_W-1:0] block,      // requested block
	input  wire  [`DC_LINE_W-1:0]  victim_line,
	input  wire                    mem_ready,
	output logic                   proc_stall,
	output logic                   fill,
	output logic                   mark_dirty,
	output logic                   word_write,
	output logic                   line_fill,
	output logic                   mem_read,
	output logic                   mem_write,
	output logic [`DC_BLOCK_W-1:0] mem_addr,
	output logic [`DC_LINE_W-1:0]  mem_wdata
);

	logic [1:0] state_q;
	logic [1:0] state_d;
	logic       req;
	logic       miss;

	assign req  = proc_read | proc_write;
	assign miss = req & ~hit;

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state_q <= `DC_ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// --------------------
	// next state and outputs
	// --------------------
	always_comb begin
		state_d    = state_q;
		proc_stall = 1'b0;
		fill       = 1'b0;
		mark_dirty = 1'b0;
		word_write = 1'b0;
		line_fill  = 1'b0;
		mem_read   = 1'b0;
		mem_write  = 1'b0;
		mem_addr   = '0;
		mem_wdata  = '0;

		case (state_q)
			`DC_ST_COMPARE: begin
				proc_stall = miss;                // stall from the miss cycle on
				word_write = proc_write & hit;
				mark_dirty = proc_write & hit;
				if (miss) begin
					state_d = victim_dirty ? `DC_ST_WRITE_BACK : `DC_ST_ALLOCATE;
				end
			end

			`DC_ST_WRITE_BACK: begin
				proc_stall = 1'b1;
				mem_write  = ~mem_ready;          // drop in the ready cycle
				mem_addr   = {victim_tag, index};  // victim's own block
				mem_wdata  = victim_line;
				if (mem_ready) begin
					state_d = `DC_ST_ALLOCATE;
				end
			end

			`DC_ST_ALLOCATE: begin
				proc_stall = 1'b1;
				mem_read   = ~mem_ready;
				mem_addr   = block;
				if (mem_ready) begin
					fill      = 1'b1;  // tag, valid, pointer
					line_fill = 1'b1;  // data
					state_d   = `DC_ST_COMPARE;
				end
			end

			default: begin
				// idle, stall stays low
				state_d = `DC_ST_COMPARE;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: cache_data_store.sv
// data cache line storage
`timescale 1ns/10ps
`default_nettype none

`include "dcache_macros.svh"

module cache_data_store import dcache_pkg::*; (
	input  wire                    clk,
	input  wire dc_addr_t          addr,
	input  wire                    hit_way,
	input  wire                    victim_way,
	input  wire                    word_write,  // store hit
	input  wire                    line_fill,   // refill from memory
	input  wire  [`DC_WORD_W-1:0]  wdata,
	input  wire  [`DC_LINE_W-1:0]  fill_line,
	output logic [`DC_WORD_W-1:0]  rd_word,
	output logic [`DC_LINE_W-1:0]  victim_line
);

	logic [`DC_LINE_W-1:0] line_q [2][`DC_SETS];  // way, set

	logic [`DC_INDEX_W-1:0]  index;
	logic [`DC_OFFSET_W-1:0] offset;

	assign index  = addr.lookup.index;
	assign offset = addr.lookup.offset;

	// --------------------
	// read side
	// --------------------
	assign rd_word     = line_q[hit_way][index][offset*`DC_WORD_W +: `DC_WORD_W];
	assign victim_line = line_q[victim_way][index];  // write-back payload

	// --------------------
	// write side
	// --------------------
	// fill and store hit never overlap, the FSM keeps them apart
	always_ff @(posedge clk) begin
		if (line_fill) begin
			line_q[victim_way][index] <= fill_line;
		end else if (word_write) begin
			line_q[hit_way][index][offset*`DC_WORD_W +: `DC_WORD_W] <= wdata;
		end
	end

endmodule

`default_nettype wire

// File: cache_tag_store.sv
// data cache tag and state array
`timescale 1ns/10ps
`default_nettype none

`include "dcache_macros.svh"

module cache_tag_store import dcache_pkg::*; (
	input  wire                   clk,
	input  wire                   proc_reset,
	input  wire dc_addr_t         addr,
	input  wire                   fill,        // line arrives, install tag
	input  wire                   mark_dirty,  // write hit
	input  wire                   fill_way,
	output logic                  hit,
	output logic                  hit_way,
	output logic                  victim_way,
	output logic                  victim_dirty,
	output logic [`DC_TAG_W-1:0]  victim_tag
);

	// --------------------
	// state per set and way
	// --------------------
	logic [`DC_TAG_W-1:0] tag_q [2][`DC_SETS];
	logic [1:0]           valid_q [`DC_SETS];  // bit n for way n
	logic [1:0]           dirty_q [`DC_SETS];
	logic [`DC_SETS-1:0]  ptr_q;               // round-robin, flips on fill

	logic [`DC_INDEX_W-1:0] index;
	logic [1:0]             way_hit;

	assign index = addr.lookup.index;

	// --------------------
	// lookup
	// --------------------
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			way_hit[w] = valid_q[index][w] && (tag_q[w][index] == addr.lookup.tag);
		end
	end

	assign hit     = |way_hit;
	assign hit_way = way_hit[1];  // way 0 unless way 1 matched

	// victim comes straight from the pointer, valid or not
	assign victim_way   = ptr_q[index];
	assign victim_dirty = dirty_q[index][victim_way];
	assign victim_tag   = tag_q[victim_way][index];

	// --------------------
	// update
	// --------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			for (int s = 0; s < `DC_SETS; s++) begin
				valid_q[s] <= 2'b00;
				dirty_q[s] <= 2'b00;
			end
			ptr_q <= '0;
		end else begin
			if (fill) begin
				valid_q[index][fill_way] <= 1'b1;
				dirty_q[index][fill_way] <= 1'b0;  // fresh copy of memory
				ptr_q[index]             <= ~ptr_q[index];
			end else if (mark_dirty) begin
				dirty_q[index][hit_way] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fill) begin
			tag_q[fill_way][index] <= addr.lookup.tag;
		end
	end

endmodule

`default_nettype wire

// File: dcache.sv
// two-way write-back data cache
`timescale 1ns/10ps
`default_nettype none

`include "dcache_macros.svh"

module dcache import dcache_pkg::*; (
	input  wire                    clk,
	input  wire                    proc_reset,
	// processor side
	input  wire                    proc_read,
	input  wire                    proc_write,
	input  wire dc_addr_t          proc_addr,
	input  wire  [`DC_WORD_W-1:0]  proc_wdata,
	output logic                   proc_stall,
	output logic [`DC_WORD_W-1:0]  proc_rdata,
	// memory side
	input  wire  [`DC_LINE_W-1:0]  mem_rdata,
	input  wire                    mem_ready,
	output logic                   mem_read,
	output logic                   mem_write,
	output logic [`DC_BLOCK_W-1:0] mem_addr,
	output logic [`DC_LINE_W-1:0]  mem_wdata
);

	// --------------------
	// internal wires
	// --------------------
	logic                   hit;
	logic                   hit_way;
	logic                   victim_way;
	logic                   victim_dirty;
	logic [`DC_TAG_W-1:0]   victim_tag;
	logic [`DC_LINE_W-1:0]  victim_line;
	logic                   fill;
	logic                   mark_dirty;
	logic                   word_write;
	logic                   line_fill;
	logic [`DC_INDEX_W-1:0] index;
	logic [`DC_BLOCK_W-1:0] block;

	assign index = proc_addr.lookup.index;  // cache view
	assign block = proc_addr.mem.block;     // memory view

	cache_tag_store tag_store_inst (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.addr         (proc_addr),
		.fill         (fill),
		.mark_dirty   (mark_dirty),
		.fill_way     (victim_way),  // fills always land on the victim
		.hit          (hit),
		.hit_way      (hit_way),
		.victim_way   (victim_way),
		.victim_dirty (victim_dirty),
		.victim_tag   (victim_tag)
	);

	cache_data_store data_store_inst (
		.clk         (clk),
		.addr        (proc_addr),
		.hit_way     (hit_way),
		.victim_way  (victim_way),
		.word_write  (word_write),
		.line_fill   (line_fill),
		.wdata       (proc_wdata),
		.fill_line   (mem_rdata),
		.rd_word     (proc_rdata),
		.victim_line (victim_line)
	);

	cache_ctrl ctrl_inst (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.proc_read    (proc_read),
		.proc_write   (proc_write),
		.hit          (hit),
		.victim_dirty (victim_dirty),
		.victim_tag   (victim_tag),
		.index        (index),
		.block        (block),
		.victim_line  (victim_line),
		.mem_ready    (mem_ready),
		.proc_stall   (proc_stall),
		.fill         (fill),
		.mark_dirty   (mark_dirty),
		.word_write   (word_write),
		.line_fill    (line_fill),
		.mem_read     (mem_read),
		.mem_write    (mem_write),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata)
	);

endmodule

`default_nettype wire

// File: dcache_macros.svh
// data cache widths and state codes
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// --------------------
// address and data widths
// --------------------
`define DC_ADDR_W    30   // processor word address
`define DC_WORD_W    32
`define DC_LINE_W    128  // four words per line
`define DC_BLOCK_W   28   // memory block number

// --------------------
// address split
// --------------------
`define DC_TAG_W     26
`define DC_INDEX_W   2
`define DC_OFFSET_W  2    // word within line
`define DC_SETS      4

// --------------------
// controller states
// --------------------
`define DC_ST_COMPARE     2'b00
`define DC_ST_WRITE_BACK  2'b01
`define DC_ST_ALLOCATE    2'b10
`define DC_ST_IDLE        2'b11  // one cycle out of reset

`endif

// File: dcache_pkg.sv
// data cache address types
`default_nettype none

`include "dcache_macros.svh"

package dcache_pkg;

	// address as the cache sees it
	typedef struct packed {
		logic [`DC_TAG_W-1:0]    tag;
		logic [`DC_INDEX_W-1:0]  index;   // set select
		logic [`DC_OFFSET_W-1:0] offset;  // word in line
	} cache_lookup_t;

	// address as memory sees it
	typedef struct packed {
		logic [`DC_BLOCK_W-1:0]  block;   // tag and index together
		logic [`DC_OFFSET_W-1:0] offset;
	} block_addr_t;

	// one processor word address, two decodings
	typedef union packed {
		cache_lookup_t lookup;
		block_addr_t   mem;
	} dc_addr_t;

endpackage

`default_nettype wire

// File: dcache_props.sv
// memory bus checks for the data cache
`timescale 1ns/10ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_props (
	input wire                   clk,
	input wire                   proc_reset,
	input wire                   proc_stall,
	input wire                   mem_read,
	input wire                   mem_write,
	input wire                   mem_ready,
	input wire [`DC_BLOCK_W-1:0] mem_addr,
	input wire [`DC_LINE_W-1:0]  mem_wdata
);

	// bus quiet right after reset
	reset_quiet: assert property (@(posedge clk)
		proc_reset |=> !mem_read && !mem_write && !proc_stall)
		else $error("memory bus or stall active after reset");

	one_direction: assert property (@(posedge clk) disable iff (proc_reset)
		!(mem_read && mem_write))
		else $error("mem_read and mem_write high together");

	// request held with a stable address until ready
	read_held: assert property (@(posedge clk) disable iff (proc_reset)
		mem_read |=> (mem_read || mem_ready) && $stable(mem_addr))
		else $error("read request dropped or address moved before mem_ready");

	write_held: assert property (@(posedge clk) disable iff (proc_reset)
		mem_write |=> (mem_write || mem_ready) && $stable(mem_addr) && $stable(mem_wdata))
		else $error("write request dropped or payload moved before mem_ready");

	ready_drops_request: assert property (@(posedge clk) disable iff (proc_reset)
		mem_ready |-> !mem_read && !mem_write)
		else $error("request still high in the mem_ready cycle");

	stall_on_traffic: assert property (@(posedge clk) disable iff (proc_reset)
		(mem_read || mem_write) |-> proc_stall)
		else $error("memory traffic without processor stall");

endmodule

bind dcache dcache_props dcache_props_inst (
	.clk        (clk),
	.proc_reset (proc_reset),
	.proc_stall (proc_stall),
	.mem_read   (mem_read),
	.mem_write  (mem_write),
	.mem_ready  (mem_ready),
	.mem_addr   (mem_addr),
	.mem_wdata  (mem_wdata)
);

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache -f sources.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_dcache 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Finished with no errors"; then
	exit 0
fi
exit 1

// File: sources.f
+incdir+.
dcache_pkg.sv
cache_tag_store.sv
cache_data_store.sv
cache_ctrl.sv
dcache.sv
dcache_props.sv
tb_dcache.sv

// File: tb_dcache.sv
// data cache testbench
`timescale 1ns/10ps
`default_nettype none

`include "dcache_macros.svh"

module tb_dcache;

	localparam int MEM_AW    = 6;   // memory model holds 64 blocks
	localparam int STALL_MAX = 40;  // cycles

	logic                   clk;
	logic                   proc_reset;
	logic                   proc_read;
	logic                   proc_write;
	logic [`DC_ADDR_W-1:0]  proc_addr;
	logic [`DC_WORD_W-1:0]  proc_wdata;
	logic                   proc_stall;
	logic [`DC_WORD_W-1:0]  proc_rdata;
	logic [`DC_LINE_W-1:0]  mem_rdata;
	logic                   mem_ready;
	logic                   mem_read;
	logic                   mem_write;
	logic [`DC_BLOCK_W-1:0] mem_addr;
	logic [`DC_LINE_W-1:0]  mem_wdata;

	dcache dcache_inst (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_read  (proc_read),
		.proc_write (proc_write),
		.proc_addr  (proc_addr),
		.proc_wdata (proc_wdata),
		.proc_stall (proc_stall),
		.proc_rdata (proc_rdata),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata)
	);

	always #20 clk = ~clk;

	logic [31:0] lcg_state = 32'he3d5_266b;
	int          err_count;
	int          check_count;
	logic        hung;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_value(input string what, input logic [127:0] got,
		input logic [127:0] exp);
		check_count++;
		if (got !== exp) begin
			$display("[FAIL] %0t: %s got %0h expected %0h", $time, what, got, exp);
			err_count++;
		end
	endtask

	// --------------------
	// memory model
	// --------------------
	logic [`DC_LINE_W-1:0]  mem_blocks [2**MEM_AW];
	logic                   mem_busy;
	int                     mem_wait;
	bit                     traffic_log [$];  // 1 write, 0 read
	logic [`DC_BLOCK_W-1:0] wb_seen_block;
	logic [`DC_LINE_W-1:0]  wb_seen_line;
	logic [`DC_BLOCK_W-1:0] rd_seen_block;

	always @(negedge clk) begin
		if (proc_reset) begin
			mem_ready = 1'b0;
			mem_busy  = 1'b0;
		end else if (mem_ready) begin
			mem_ready = 1'b0;  // one-cycle pulse
		end else if ((mem_read || mem_write) && !mem_busy) begin
			mem_busy = 1'b1;
			mem_wait = 1 + int'(lcg_next() % 32'd4);
		end else if (mem_busy) begin
			mem_wait = mem_wait - 1;
			if (mem_wait == 0) begin
				if (mem_addr[`DC_BLOCK_W-1:MEM_AW] != '0) begin
					$display("memory model: block address %0h is outside the model", mem_addr);
					err_count++;
				end else if (mem_write) begin
					mem_blocks[mem_addr[MEM_AW-1:0]] = mem_wdata;
					wb_seen_block = mem_addr;
					wb_seen_line  = mem_wdata;
					traffic_log.push_back(1'b1);
				end else begin
					mem_rdata     = mem_blocks[mem_addr[MEM_AW-1:0]];
					rd_seen_block = mem_addr;
					traffic_log.push_back(1'b0);
				end
				mem_busy  = 1'b0;
				mem_ready = 1'b1;
			end
		end
	end

	// --------------------
	// reference model
	// --------------------
	logic [`DC_LINE_W-1:0] ref_mem [2**MEM_AW];
	logic [`DC_LINE_W-1:0] ref_line [2][`DC_SETS];
	logic [`DC_TAG_W-1:0]  ref_tag [2][`DC_SETS];
	logic                  ref_valid [2][`DC_SETS];
	logic                  ref_dirty [2][`DC_SETS];
	logic                  ref_ptr [`DC_SETS];  // flips on every fill

	// traffic: 0 none, 1 fill only, 2 write-back then fill
	task automatic model_access(input logic wr, input logic [`DC_ADDR_W-1:0] addr,
		input logic [`DC_WORD_W-1:0] wdata, output logic [`DC_WORD_W-1:0] word,
		output logic [1:0] traffic, output logic [`DC_BLOCK_W-1:0] wb_block,
		output logic [`DC_LINE_W-1:0] wb_line);
		logic [`DC_BLOCK_W-1:0]  blk;
		logic [`DC_INDEX_W-1:0]  set;
		logic [`DC_TAG_W-1:0]    tag;
		logic [`DC_OFFSET_W-1:0] off;
		int                      way;
		blk      = addr[`DC_ADDR_W-1:2];
		off      = addr[1:0];
		set      = blk[1:0];
		tag      = blk[`DC_BLOCK_W-1:2];
		traffic  = 2'd0;
		wb_block = '0;
		wb_line  = '0;
		way      = -1;
		for (int w = 0; w < 2; w++) begin
			if (ref_valid[w][set] && ref_tag[w][set] == tag)
				way = w;
		end
		if (way < 0) begin
			way     = int'(ref_ptr[set]);
			traffic = 2'd1;
			if (ref_valid[way][set] && ref_dirty[way][set]) begin
				traffic  = 2'd2;
				wb_block = {ref_tag[way][set], set};
				wb_line  = ref_line[way][set];
				ref_mem[wb_block[MEM_AW-1:0]] = wb_line;
			end
			ref_line[way][set]  = ref_mem[blk[MEM_AW-1:0]];
			ref_tag[way][set]   = tag;
			ref_valid[way][set] = 1'b1;
			ref_dirty[way][set] = 1'b0;
			ref_ptr[set]        = ~ref_ptr[set];
		end
		if (wr) begin
			ref_line[way][set][off*32 +: 32] = wdata;
			ref_dirty[way][set] = 1'b1;
		end
		word = ref_line[way][set][off*32 +: 32];
	endtask

	function automatic logic [1:0] traffic_code();
		if (traffic_log.size() == 0) return 2'd0;
		if (traffic_log.size() == 1 && !traffic_log[0]) return 2'd1;
		if (traffic_log.size() == 2 && traffic_log[0] && !traffic_log[1]) return 2'd2;
		return 2'd3;
	endfunction

	// --------------------
	// stimulus table
	// --------------------
	bit                    tbl_write [$];
	logic [`DC_ADDR_W-1:0] tbl_addr [$];
	logic [`DC_WORD_W-1:0] tbl_wdata [$];
	bit                    tbl_mem [$];  // memory traffic expected

	task automatic add_entry(input bit wr, input logic [`DC_ADDR_W-1:0] addr,
		input logic [`DC_WORD_W-1:0] wdata, input bit mem);
		tbl_write.push_back(wr);
		tbl_addr.push_back(addr);
		tbl_wdata.push_back(wdata);
		tbl_mem.push_back(mem);
	endtask

	task automatic load_table();
		add_entry(1'b0, 30'd22, 32'h0, 1'b1);          // block 5, set 1, clean miss
		add_entry(1'b0, 30'd22, 32'h0, 1'b0);          // same line hits
		add_entry(1'b1, 30'd21, 32'hcafe_0001, 1'b0);  // write hit
		add_entry(1'b0, 30'd21, 32'h0, 1'b0);
		add_entry(1'b0, 30'd36, 32'h0, 1'b1);          // block 9 takes way 1
		add_entry(1'b0, 30'd55, 32'h0, 1'b1);          // block 13 evicts dirty block 5
		add_entry(1'b0, 30'd36, 32'h0, 1'b0);
		add_entry(1'b0, 30'd21, 32'h0, 1'b1);          // written-back word returns
		add_entry(1'b1, 30'd8,  32'h1234_5678, 1'b1);  // write miss, set 2
		add_entry(1'b0, 30'd8,  32'h0, 1'b0);
		add_entry(1'b1, 30'd27, 32'h0bad_f00d, 1'b1);
		add_entry(1'b0, 30'd40, 32'h0, 1'b1);          // evicts dirty block 2
		add_entry(1'b0, 30'd8,  32'h0, 1'b1);          // evicts dirty block 6
		add_entry(1'b0, 30'd27, 32'h0, 1'b1);
		add_entry(1'b0, 30'd3,  32'h0, 1'b1);          // set 0
		add_entry(1'b1, 30'd63, 32'h5a5a_0f0f, 1'b1);  // set 3
		add_entry(1'b0, 30'd63, 32'h0, 1'b0);
	endtask

	// drive on the falling edge, done at the first rising edge with stall low
	task automatic run_request(input bit wr, input logic [`DC_ADDR_W-1:0] addr,
		input logic [`DC_WORD_W-1:0] wdata, output logic [`DC_WORD_W-1:0] rdata,
		output int stall_cycles);
		int waited;
		waited = 0;
		@(negedge clk);
		proc_read  = ~wr;
		proc_write = wr;
		proc_addr  = addr;
		proc_wdata = wdata;
		#5;
		while (proc_stall && waited < STALL_MAX) begin
			@(negedge clk);
			#5;
			waited++;
		end
		rdata        = proc_rdata;
		stall_cycles = waited;
		if (proc_stall) begin
			$display("timeout: proc_stall stayed high for %0d cycles", waited);
			hung = 1'b1;
		end
		@(negedge clk);
		proc_read  = 1'b0;
		proc_write = 1'b0;
	endtask

	initial begin
		int                     errs_before;
		int                     stall_cycles;
		logic [`DC_WORD_W-1:0]  exp_word;
		logic [`DC_WORD_W-1:0]  got_word;
		logic [1:0]             exp_traffic;
		logic [`DC_BLOCK_W-1:0] exp_wb_block;
		logic [`DC_LINE_W-1:0]  exp_wb_line;
		logic [`DC_ADDR_W-1:0]  req_addr;
		clk         = 1'b0;
		proc_reset  = 1'b1;
		proc_read   = 1'b0;
		proc_write  = 1'b0;
		proc_addr   = '0;
		proc_wdata  = '0;
		mem_rdata   = '0;
		mem_ready   = 1'b0;
		err_count   = 0;
		check_count = 0;
		hung        = 1'b0;
		for (int b = 0; b < 2**MEM_AW; b++) begin
			for (int w = 0; w < 4; w++)
				mem_blocks[b][w*32 +: 32] = lcg_next();
			ref_mem[b] = mem_blocks[b];
		end
		for (int s = 0; s < `DC_SETS; s++) begin
			ref_ptr[s] = 1'b0;
			for (int w = 0; w < 2; w++) begin
				ref_valid[w][s] = 1'b0;
				ref_dirty[w][s] = 1'b0;
			end
		end
		load_table();
		repeat (10) @(negedge clk);
		proc_reset = 1'b0;

		// quiet bus after reset, idle cycle then compare
		repeat (2) begin
			@(negedge clk);
			#5;
			check_value("mem_read after reset", mem_read, 1'b0);
			check_value("mem_write after reset", mem_write, 1'b0);
			check_value("proc_stall after reset", proc_stall, 1'b0);
		end
		$display("test reset: %s", err_count == 0 ? "ok" : "FAILED");

		for (int i = 0; i < tbl_addr.size() && !hung; i++) begin
			errs_before = err_count;
			traffic_log.delete();
			req_addr = tbl_addr[i];
			model_access(tbl_write[i], req_addr, tbl_wdata[i], exp_word, exp_traffic,
				exp_wb_block, exp_wb_line);
			run_request(tbl_write[i], req_addr, tbl_wdata[i], got_word, stall_cycles);
			if (!hung) begin
				if (!tbl_write[i])
					check_value("read data", got_word, exp_word);
				check_value("memory traffic order", traffic_code(), exp_traffic);
				check_value("memory traffic present", traffic_code() != 2'd0, tbl_mem[i]);
				check_value("stall present", stall_cycles != 0, tbl_mem[i]);
				if (exp_traffic != 2'd0)
					check_value("fill block", rd_seen_block, req_addr[`DC_ADDR_W-1:2]);
				if (exp_traffic == 2'd2) begin
					check_value("write-back block", wb_seen_block, exp_wb_block);
					check_value("write-back line", wb_seen_line, exp_wb_line);
					check_value("memory after write-back",
						mem_blocks[exp_wb_block[MEM_AW-1:0]], exp_wb_line);
				end
			end
			$display("test %0d %s addr %0h: %s", i, tbl_write[i] ? "write" : "read",
				tbl_addr[i], err_count == errs_before ? "ok" : "FAILED");
		end

		$display("checks %0d, errors %0d, timeout %0d", check_count, err_count, hung);
		if (err_count == 0 && !hung) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire
